//--- build.f
hw/projection_pkg.sv
hw/column_map_ram.sv
hw/frame_sequencer.sv
hw/run_edge_finder.sv
hw/target_list_assembler.sv
hw/projection_top.sv
verif/projection_sva.sv
verif/tb_projection.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_projection
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Verification passed

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# pass only when the pass line shows up in the output
run: $(SIM)
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- verif/tb_projection.sv
`timescale 1ns/1ps
`default_nettype none

module tb_projection
  import projection_pkg::*;
();

  localparam int BLANK_CYC = 16;
  localparam int LINE_CYC  = LINE_WIDTH + BLANK_CYC;
  localparam int FRAME_LEN = 16 + 8 * LINE_CYC;
  localparam int TIMEOUT   = 2 * 5 * 3 * FRAME_LEN;

  logic                              pixelclk;
  logic                              reset_n;
  logic [PIX_W-1:0]                  i_binary;
  logic                              i_hs, i_vs, i_de;
  logic [COL_W-1:0]                  i_hcount, i_vcount;
  logic [MAX_TARGETS-1:0][COL_W-1:0] o_left, o_right;
  logic [CNT_W-1:0]                  o_count;
  logic                              o_valid;

  // frame content and expected list
  logic [LINE_WIDTH-1:0]             dark_line [4];
  logic [LINE_WIDTH-1:0]             occ;
  logic                              blank_dark;
  logic [MAX_TARGETS-1:0][COL_W-1:0] exp_left, exp_right;
  int                                exp_count;
  logic [31:0]                       seed;
  string                             test_name;
  int                                test_errs, tests_passed, tests_failed, cycles;
  bit                                checked;

  projection_top uut (
    .pixelclk (pixelclk),
    .reset_n  (reset_n),
    .i_binary (i_binary),
    .i_hs     (i_hs),
    .i_vs     (i_vs),
    .i_de     (i_de),
    .i_hcount (i_hcount),
    .i_vcount (i_vcount),
    .o_left   (o_left),
    .o_right  (o_right),
    .o_count  (o_count),
    .o_valid  (o_valid)
  );

  initial begin
    pixelclk = 1'b0;
    forever #4 pixelclk = ~pixelclk;
  end

  always @(posedge pixelclk) begin
    cycles++;
    if (cycles >= TIMEOUT) begin
      $display("timeout: no result published within %0d cycles", TIMEOUT);
      $display("Verification failed");
      $finish;
    end
  end

  // ----------------------------------------
  // reference model
  // ----------------------------------------
  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic int rand_below(input int n);
    seed = lcg_next(seed);
    return int'(seed[23:8]) % n;
  endfunction

  // runs of occupied columns with the first MAX_TARGETS kept
  function automatic void ref_targets(input logic [LINE_WIDTH-1:0] cols,
                                      output logic [MAX_TARGETS-1:0][COL_W-1:0] lefts,
                                      output logic [MAX_TARGETS-1:0][COL_W-1:0] rights,
                                      output int count);
    int   start;
    logic in_run;
    logic now;
    lefts  = '0;
    rights = '0;
    count  = 0;
    start  = 0;
    in_run = 1'b0;
    for (int c = 0; c <= LINE_WIDTH; c++) begin
      now = (c < LINE_WIDTH) && cols[c];
      if (now && !in_run) begin
        start = c;
      end
      if (!now && in_run && count < MAX_TARGETS) begin
        lefts[count]  = COL_W'(start);
        rights[count] = COL_W'(c - 1);
        count++;
      end
      in_run = now;
    end
  endfunction

  // ----------------------------------------
  // checks and reporting
  // ----------------------------------------
  task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("ERR %s %s expected %0d actual %0d", test_name, what, exp, act);
      test_errs++;
    end
  endtask

  task automatic compare_outputs();
    check("count", 32'(exp_count), 32'(o_count));
    for (int k = 0; k < MAX_TARGETS; k++) begin
      check($sformatf("left[%0d]", k), 32'(exp_left[k]), 32'(o_left[k]));
      check($sformatf("right[%0d]", k), 32'(exp_right[k]), 32'(o_right[k]));
    end
  endtask

  task automatic start_test(input string name);
    test_name = name;
    test_errs = 0;
  endtask

  task automatic finish_test();
    if (test_errs == 0) begin
      tests_passed++;
      $display("test %-8s ok", test_name);
    end else begin
      tests_failed++;
      $display("test %-8s failed with %0d mismatches", test_name, test_errs);
    end
  endtask

  // compare every published list
  always @(negedge pixelclk) begin
    if (reset_n && o_valid) begin
      compare_outputs();
      checked = 1'b1;
    end
  end

  // ----------------------------------------
  // frame generator
  // ----------------------------------------
  task automatic drive_pixel(input logic vs, input logic de, input logic [COL_W-1:0] col,
                             input logic dark);
    @(posedge pixelclk);
    i_vs     <= vs;
    i_de     <= de;
    i_hcount <= col;
    i_binary <= dark ? '0 : '1;
  endtask

  task automatic paint(input int line, input int first, input int last);
    for (int c = first; c <= last; c++) begin
      dark_line[line][c] = 1'b1;
    end
  endtask

  task automatic clear_marks();
    for (int l = 0; l < 4; l++) begin
      dark_line[l] = '0;
    end
  endtask

  // vsync pulse then 4 active and 4 blank lines
  task automatic send_frame(input logic live);
    logic dark;
    repeat (16) drive_pixel(1'b1, 1'b0, '0, 1'b0);
    for (int l = 0; l < 4; l++) begin
      i_vcount <= COL_W'(l);
      for (int c = 0; c < LINE_WIDTH; c++) begin
        dark = live && dark_line[l][c];
        if (dark && c >= COL_MIN && c <= COL_MAX) begin
          occ[c] = 1'b1;
        end
        drive_pixel(1'b0, 1'b1, COL_W'(c), dark);
      end
      // dark blanking pixels carry de low
      for (int b = 0; b < BLANK_CYC; b++) begin
        drive_pixel(1'b0, 1'b0, COL_W'(200 + b), live && blank_dark);
      end
    end
    repeat (4 * LINE_CYC) drive_pixel(1'b0, 1'b0, '0, 1'b0);
  endtask

  // accumulate frame then scan frame
  task automatic run_frames(input string name);
    start_test(name);
    occ = '0;
    send_frame(1'b1);
    ref_targets(occ, exp_left, exp_right, exp_count);
    checked = 1'b0;
    send_frame(1'b0);
    while (!checked) @(posedge pixelclk);
    finish_test();
  endtask

  initial begin
    int n_tgt;
    int first;
    int width;
    int shift;
    reset_n      = 1'b0;
    i_binary     = '1;
    i_hs         = 1'b0;
    i_vs         = 1'b0;
    i_de         = 1'b0;
    i_hcount     = '0;
    i_vcount     = '0;
    blank_dark   = 1'b0;
    seed         = 32'h7e69_2646;
    cycles       = 0;
    tests_passed = 0;
    tests_failed = 0;
    checked      = 1'b0;
    occ          = '0;
    clear_marks();
    repeat (4) @(posedge pixelclk);
    reset_n <= 1'b1;

    @(negedge pixelclk);
    start_test("reset");
    exp_left  = '0;
    exp_right = '0;
    exp_count = 0;
    check("valid", 32'd0, 32'(o_valid));
    compare_outputs();
    finish_test();
    // memory is cleared before the first frame
    repeat (LINE_WIDTH + 16) @(posedge pixelclk);

    paint(1, 100, 163);
    run_frames("single");

    clear_marks();
    n_tgt = 3 + rand_below(4);
    for (int t = 0; t < n_tgt; t++) begin
      first = 3 + rand_below(960);
      width = 1 + rand_below(48);
      shift = rand_below(4);
      for (int c = first; c < first + width; c++) begin
        dark_line[(c + shift) % 4][c] = 1'b1;
      end
    end
    run_frames("random");

    clear_marks();
    for (int k = 0; k < 11; k++) begin
      paint(k % 4, 20 + k * 40, 21 + k * 40);
    end
    run_frames("overflow");

    clear_marks();
    paint(0, 0, 2);
    paint(3, 1022, 1023);
    paint(2, 500, 520);
    blank_dark = 1'b1;
    run_frames("margin");
    blank_dark = 1'b0;

    clear_marks();
    run_frames("white");

    $display("tests passed %0d, failed %0d", tests_passed, tests_failed);
    if (tests_failed == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verif/projection_sva.sv
`timescale 1ns/1ps
`default_nettype none

module projection_sva
  import projection_pkg::*;
(
  input wire        pixelclk,
  input wire        reset_n,
  input var phase_t phase,
  input wire        vs_fall,
  input wire        wr_en,
  input wire        scan_done
);

  // marks must stay frozen while the sweep reads them
  no_write_in_scan: assert property (@(posedge pixelclk) disable iff (!reset_n)
    (phase == SCAN) |-> !wr_en)
    else $error("memory write while the sweep is running");

  // a short frame would land its vsync in SCAN or CLEAR
  vsync_fall_phase: assert property (@(posedge pixelclk) disable iff (!reset_n)
    vs_fall |-> ((phase == WAIT_FRAME) || (phase == ACCUMULATE)))
    else $error("falling vsync outside WAIT_FRAME and ACCUMULATE");

  scan_done_pulse: assert property (@(posedge pixelclk) disable iff (!reset_n)
    scan_done |=> !scan_done)
    else $error("scan_done held for more than one cycle");

endmodule

bind frame_sequencer projection_sva u_sva (
  .pixelclk  (pixelclk),
  .reset_n   (reset_n),
  .phase     (phase),
  .vs_fall   (vs_fall),
  .wr_en     (o_wr_en),
  .scan_done (o_scan_done)
);

`default_nettype wire

//--- hw/projection_top.sv
`timescale 1ns/1ps
`default_nettype none

module projection_top
  import projection_pkg::*;
(
  input  wire                                pixelclk,
  input  wire                                reset_n,
  input  wire  [PIX_W-1:0]                   i_binary,
  input  wire                                i_hs,
  input  wire                                i_vs,
  input  wire                                i_de,
  input  wire  [COL_W-1:0]                   i_hcount,
  input  wire  [COL_W-1:0]                   i_vcount,
  output logic [MAX_TARGETS-1:0][COL_W-1:0]  o_left,
  output logic [MAX_TARGETS-1:0][COL_W-1:0]  o_right,
  output logic [CNT_W-1:0]                   o_count,
  output logic                               o_valid
);

  // memory ports
  logic             wr_en;
  logic [COL_W-1:0] wr_addr;
  logic             wr_bit;
  logic [COL_W-1:0] rd_addr;

  // sweep stream
  logic             scan_start;
  logic             scan_valid;
  logic [COL_W-1:0] scan_col;
  logic             scan_bit;
  logic             scan_done;

  logic [MAX_TARGETS-1:0][COL_W-1:0] left_cols;
  logic [MAX_TARGETS-1:0][COL_W-1:0] right_cols;
  logic [CNT_W-1:0]                  right_count;

  frame_sequencer u_sequencer (
    .pixelclk     (pixelclk),
    .reset_n      (reset_n),
    .i_binary     (i_binary),
    .i_vs         (i_vs),
    .i_de         (i_de),
    .i_hcount     (i_hcount),
    .o_wr_en      (wr_en),
    .o_wr_addr    (wr_addr),
    .o_wr_bit     (wr_bit),
    .o_rd_addr    (rd_addr),
    .o_scan_start (scan_start),
    .o_scan_valid (scan_valid),
    .o_scan_col   (scan_col),
    .o_scan_done  (scan_done)
  );

  column_map_ram #(
    .DEPTH  (LINE_WIDTH),
    .ADDR_W (COL_W)
  ) u_ram (
    .pixelclk  (pixelclk),
    .i_wr_en   (wr_en),
    .i_wr_addr (wr_addr),
    .i_wr_bit  (wr_bit),
    .i_rd_addr (rd_addr),
    .o_rd_bit  (scan_bit)
  );

  // ----------------------------------------
  // run boundary finders
  // ----------------------------------------
  run_edge_finder #(.FALLING(1'b0)) u_left_finder (
    .pixelclk     (pixelclk),
    .reset_n      (reset_n),
    .i_scan_start (scan_start),
    .i_scan_valid (scan_valid),
    .i_scan_col   (scan_col),
    .i_scan_bit   (scan_bit),
    .o_cols       (left_cols),
    .o_count      ()
  );

  run_edge_finder #(.FALLING(1'b1)) u_right_finder (
    .pixelclk     (pixelclk),
    .reset_n      (reset_n),
    .i_scan_start (scan_start),
    .i_scan_valid (scan_valid),
    .i_scan_col   (scan_col),
    .i_scan_bit   (scan_bit),
    .o_cols       (right_cols),
    .o_count      (right_count)
  );

  target_list_assembler u_assembler (
    .pixelclk      (pixelclk),
    .reset_n       (reset_n),
    .i_scan_done   (scan_done),
    .i_left_cols   (left_cols),
    .i_right_cols  (right_cols),
    .i_right_count (right_count),
    .o_left        (o_left),
    .o_right       (o_right),
    .o_count       (o_count),
    .o_valid       (o_valid)
  );

endmodule

`default_nettype wire

//--- hw/target_list_assembler.sv
`timescale 1ns/1ps
`default_nettype none

module target_list_assembler
  import projection_pkg::*;
(
  input  wire                                pixelclk,
  input  wire                                reset_n,
  input  wire                                i_scan_done,
  input  wire  [MAX_TARGETS-1:0][COL_W-1:0]  i_left_cols,
  input  wire  [MAX_TARGETS-1:0][COL_W-1:0]  i_right_cols,
  input  wire  [CNT_W-1:0]                   i_right_count,
  output logic [MAX_TARGETS-1:0][COL_W-1:0]  o_left,
  output logic [MAX_TARGETS-1:0][COL_W-1:0]  o_right,
  output logic [CNT_W-1:0]                   o_count,
  output logic                               o_valid
);

  // ----------------------------------------
  // publish register
  // ----------------------------------------
  always_ff @(posedge pixelclk or negedge reset_n) begin
    if (!reset_n) begin
      o_left  <= '0;
      o_right <= '0;
      o_count <= '0;
      o_valid <= 1'b0;
    end else begin
      o_valid <= i_scan_done;
      // list holds until the next sweep ends
      if (i_scan_done) begin
        o_left  <= i_left_cols;
        o_right <= i_right_cols;
        o_count <= i_right_count;
      end
    end
  end

endmodule

`default_nettype wire

//--- hw/run_edge_finder.sv
`timescale 1ns/1ps
`default_nettype none

module run_edge_finder
  import projection_pkg::*;
#(
  parameter bit FALLING = 1'b0
) (
  input  wire                                pixelclk,
  input  wire                                reset_n,
  input  wire                                i_scan_start,
  input  wire                                i_scan_valid,
  input  wire  [COL_W-1:0]                   i_scan_col,
  input  wire                                i_scan_bit,
  output logic [MAX_TARGETS-1:0][COL_W-1:0]  o_cols,
  output logic [CNT_W-1:0]                   o_count
);

  localparam int SLOT_W = $clog2(MAX_TARGETS);

  logic prev_bit;
  logic edge_hit;
  logic slot_free;

  // rising instance sees 0 to 1 and falling instance sees 1 to 0
  assign edge_hit  = FALLING ? (prev_bit & ~i_scan_bit) : (~prev_bit & i_scan_bit);
  assign slot_free = (o_count < CNT_W'(MAX_TARGETS));

  always_ff @(posedge pixelclk or negedge reset_n) begin
    if (!reset_n) begin
      prev_bit <= 1'b0;
      o_cols   <= '0;
      o_count  <= '0;
    end else if (i_scan_start) begin
      prev_bit <= 1'b0;
      o_cols   <= '0;
      o_count  <= '0;
    end else if (i_scan_valid) begin
      prev_bit <= i_scan_bit;
      // extra edges past the last slot are dropped
      if (edge_hit && slot_free) begin
        if (FALLING) begin
          // run ended on the column before this one
          o_cols[o_count[SLOT_W-1:0]] <= i_scan_col - 1'b1;
        end else begin
          o_cols[o_count[SLOT_W-1:0]] <= i_scan_col;
        end
        o_count <= o_count + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- hw/frame_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module frame_sequencer
  import projection_pkg::*;
(
  input  wire              pixelclk,
  input  wire              reset_n,
  input  wire  [PIX_W-1:0] i_binary,
  input  wire              i_vs,
  input  wire              i_de,
  input  wire  [COL_W-1:0] i_hcount,
  output logic             o_wr_en,
  output logic [COL_W-1:0] o_wr_addr,
  output logic             o_wr_bit,
  output logic [COL_W-1:0] o_rd_addr,
  output logic             o_scan_start,
  output logic             o_scan_valid,
  output logic [COL_W-1:0] o_scan_col,
  output logic             o_scan_done
);

  logic             vs_r;
  logic             vs_fall;
  phase_t           phase;
  logic [COL_W-1:0] addr;
  logic             addr_last;
  logic             pix_hit;
  logic             scan_last;

  // ----------------------------------------
  // vsync falling edge
  // ----------------------------------------
  always_ff @(posedge pixelclk or negedge reset_n) begin
    if (!reset_n) begin
      vs_r <= 1'b0;
    end else begin
      vs_r <= i_vs;
    end
  end

  assign vs_fall = vs_r & ~i_vs;

  assign addr_last = (addr == COL_W'(LINE_WIDTH - 1));

  // dark active pixel inside the column window
  assign pix_hit = i_de && (i_binary == '0) &&
                   (i_hcount >= COL_W'(COL_MIN)) && (i_hcount <= COL_W'(COL_MAX));

  // ----------------------------------------
  // phase FSM and shared address counter
  // ----------------------------------------
  always_ff @(posedge pixelclk or negedge reset_n) begin
    if (!reset_n) begin
      phase        <= INIT;
      addr         <= '0;
      o_scan_start <= 1'b0;
    end else begin
      o_scan_start <= 1'b0;
      case (phase)
        INIT, CLEAR: begin
          addr <= addr + 1'b1;
          if (addr_last) begin
            phase <= WAIT_FRAME;
            addr  <= '0;
          end
        end
        WAIT_FRAME: begin
          if (vs_fall) begin
            phase <= ACCUMULATE;
          end
        end
        ACCUMULATE: begin
          // start pulse lands one cycle ahead of column 0
          if (vs_fall) begin
            phase        <= SCAN;
            addr         <= '0;
            o_scan_start <= 1'b1;
          end
        end
        SCAN: begin
          addr <= addr + 1'b1;
          if (addr_last) begin
            phase <= CLEAR;
            addr  <= '0;
          end
        end
        default: begin
          phase <= INIT;
          addr  <= '0;
        end
      endcase
    end
  end

  assign o_rd_addr = addr;

  // ----------------------------------------
  // memory write port
  // ----------------------------------------
  always_ff @(posedge pixelclk or negedge reset_n) begin
    if (!reset_n) begin
      o_wr_en   <= 1'b0;
      o_wr_addr <= '0;
      o_wr_bit  <= 1'b0;
    end else begin
      case (phase)
        INIT, CLEAR: begin
          o_wr_en   <= 1'b1;
          o_wr_addr <= addr;
          o_wr_bit  <= 1'b0;
        end
        ACCUMULATE: begin
          o_wr_en   <= pix_hit;
          o_wr_addr <= i_hcount;
          o_wr_bit  <= 1'b1;
        end
        default: begin
          o_wr_en <= 1'b0;
        end
      endcase
    end
  end

  // ----------------------------------------
  // sweep stream aligned to read data
  // ----------------------------------------
  always_ff @(posedge pixelclk or negedge reset_n) begin
    if (!reset_n) begin
      o_scan_valid <= 1'b0;
      o_scan_col   <= '0;
      scan_last    <= 1'b0;
      o_scan_done  <= 1'b0;
    end else begin
      o_scan_valid <= (phase == SCAN);
      o_scan_col   <= addr;
      scan_last    <= (phase == SCAN) && addr_last;
      // done follows the last beat by one cycle
      o_scan_done  <= scan_last;
    end
  end

endmodule

`default_nettype wire

//--- hw/column_map_ram.sv
`timescale 1ns/1ps
`default_nettype none

module column_map_ram #(
  parameter int DEPTH  = 1024,
  parameter int ADDR_W = 12
) (
  input  wire              pixelclk,
  input  wire              i_wr_en,
  input  wire [ADDR_W-1:0] i_wr_addr,
  input  wire              i_wr_bit,
  input  wire [ADDR_W-1:0] i_rd_addr,
  output logic             o_rd_bit
);

  // address bits actually needed to index the array
  localparam int IDX_W = $clog2(DEPTH);

  // one mark bit per column
  logic mem [DEPTH];

  always_ff @(posedge pixelclk) begin
    if (i_wr_en) begin
      mem[i_wr_addr[IDX_W-1:0]] <= i_wr_bit;
    end
  end

  // registered read with one cycle latency
  always_ff @(posedge pixelclk) begin
    o_rd_bit <= mem[i_rd_addr[IDX_W-1:0]];
  end

endmodule

`default_nettype wire

//--- hw/projection_pkg.sv
`default_nettype none

package projection_pkg;

  // ----------------------------------------
  // line geometry
  // ----------------------------------------
  localparam int LINE_WIDTH = 1024;
  localparam int COL_W      = 12;

  // mark window keeps the edge columns out
  localparam int COL_MIN = 3;
  localparam int COL_MAX = 1021;

  // ----------------------------------------
  // result list
  // ----------------------------------------
  localparam int MAX_TARGETS = 8;
  localparam int CNT_W       = 4;

  // binarized pixel word where zero means dark
  localparam int PIX_W = 24;

  // sequencer phases
  typedef enum logic [2:0] {
    INIT       = 3'd0,
    WAIT_FRAME = 3'd1,
    ACCUMULATE = 3'd2,
    SCAN       = 3'd3,
    CLEAR      = 3'd4
  } phase_t;

endpackage

`default_nettype wire
